// ==== list.f ====
+incdir+include
hw/riscv_decoder_pkg.sv
hw/alu_op_decoder.sv
hw/mem_op_decoder.sv
hw/flow_op_decoder.sv
hw/decode_stage.sv
test/decode_stage_assert.sv
test/tb_decode_stage.sv

// ==== Makefile ====
TOP := tb_decode_stage

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f list.f -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	grep -qx "all tests passed" sim.log

lint:
	verilator --lint-only -Wall --top-module decode_stage +incdir+include \
		hw/riscv_decoder_pkg.sv hw/alu_op_decoder.sv hw/mem_op_decoder.sv \
		hw/flow_op_decoder.sv hw/decode_stage.sv

clean:
	rm -rf obj_dir sim.log

// ==== test/decode_trace.txt ====
# test valid instr alu_op a_sel b_sel mem_size wb_sel illegal mem_req mem_we gpr_we branch jal jalr
# hex values; illegal words expect the default fields and no enables.
add      1 003100B3 00 0 0 0 0 0 0 0 1 0 0 0
sub      1 403100B3 08 0 0 0 0 0 0 0 1 0 0 0
sll      1 003110B3 01 0 0 0 0 0 0 0 1 0 0 0
slt      1 003120B3 02 0 0 0 0 0 0 0 1 0 0 0
sltu     1 003130B3 03 0 0 0 0 0 0 0 1 0 0 0
xor      1 003140B3 04 0 0 0 0 0 0 0 1 0 0 0
srl      1 003150B3 05 0 0 0 0 0 0 0 1 0 0 0
sra      1 403150B3 0d 0 0 0 0 0 0 0 1 0 0 0
or       1 003160B3 06 0 0 0 0 0 0 0 1 0 0 0
and      1 003170B3 07 0 0 0 0 0 0 0 1 0 0 0
addi     1 00510093 00 0 1 0 0 0 0 0 1 0 0 0
addi_neg 1 FFF10093 00 0 1 0 0 0 0 0 1 0 0 0
slti     1 00512093 02 0 1 0 0 0 0 0 1 0 0 0
sltiu    1 00513093 03 0 1 0 0 0 0 0 1 0 0 0
xori     1 00514093 04 0 1 0 0 0 0 0 1 0 0 0
ori      1 00516093 06 0 1 0 0 0 0 0 1 0 0 0
andi     1 00517093 07 0 1 0 0 0 0 0 1 0 0 0
slli     1 00311093 01 0 1 0 0 0 0 0 1 0 0 0
srli     1 00315093 05 0 1 0 0 0 0 0 1 0 0 0
srai     1 40315093 0d 0 1 0 0 0 0 0 1 0 0 0
slli_f7  1 40311093 00 0 0 0 0 1 0 0 0 0 0 0
mul      1 023100B3 00 0 0 0 0 1 0 0 0 0 0 0
idle_op  0 003100B3 00 0 0 0 0 0 0 0 0 0 0 0
lb       1 00810083 00 0 1 0 1 0 1 0 1 0 0 0
lh       1 00811083 00 0 1 1 1 0 1 0 1 0 0 0
lw       1 00812083 00 0 1 2 1 0 1 0 1 0 0 0
lbu      1 00814083 00 0 1 4 1 0 1 0 1 0 0 0
lhu      1 00815083 00 0 1 5 1 0 1 0 1 0 0 0
ld       1 00813083 00 0 0 0 0 1 0 0 0 0 0 0
sb       1 00310423 00 0 3 0 0 0 1 1 0 0 0 0
sh       1 00311423 00 0 3 1 0 0 1 1 0 0 0 0
sw       1 00312423 00 0 3 2 0 0 1 1 0 0 0 0
sd       1 00313423 00 0 0 0 0 1 0 0 0 0 0 0
beq      1 00310463 18 0 0 0 0 0 0 0 0 1 0 0
bne      1 00311463 19 0 0 0 0 0 0 0 0 1 0 0
blt      1 00314463 1c 0 0 0 0 0 0 0 0 1 0 0
bge      1 00315463 1d 0 0 0 0 0 0 0 0 1 0 0
bltu     1 00316463 1e 0 0 0 0 0 0 0 0 1 0 0
bgeu     1 00317463 1f 0 0 0 0 0 0 0 0 1 0 0
br_f3_2  1 00312463 00 0 0 0 0 1 0 0 0 0 0 0
jal      1 008000EF 00 1 4 0 0 0 0 0 1 0 1 0
jalr     1 000100E7 00 1 4 0 0 0 0 0 1 0 0 1
jalr_f3  1 000110E7 00 0 0 0 0 1 0 0 0 0 0 0
lui      1 123450B7 00 2 2 0 0 0 0 0 1 0 0 0
auipc    1 12345097 00 1 2 0 0 0 0 0 1 0 0 0
idle_sys 0 00000073 00 0 0 0 0 0 0 0 0 0 0 0
fence    1 0FF0000F 00 0 0 0 0 0 0 0 0 0 0 0
ecall    1 00000073 00 0 0 0 0 1 0 0 0 0 0 0
csrrw    1 300110F3 00 0 0 0 0 1 0 0 0 0 0 0
unknown  1 0000007F 00 0 0 0 0 1 0 0 0 0 0 0
zero     1 00000000 00 0 0 0 0 1 0 0 0 0 0 0

// ==== test/tb_decode_stage.sv ====
`timescale 1ns/1ps

module tb_decode_stage import riscv_decoder_pkg::*; ();

    typedef logic [8*16-1:0] name_t;

    logic        clk_i;
    logic        reset_i;
    logic        valid_i;
    logic [31:0] instr_i;
    logic        valid_o;
    logic        illegal_o;
    alu_op_e     alu_op_o;
    a_sel_e      a_sel_o;
    b_sel_e      b_sel_o;
    logic        mem_req_o;
    logic        mem_we_o;
    mem_size_e   mem_size_o;
    logic        gpr_we_o;
    wb_sel_e     wb_sel_o;
    logic        branch_o;
    logic        jal_o;
    logic        jalr_o;

    int rise_count = 0;
    int fall_count = 0;
    int checks = 0;
    int errors = 0;
    int timeouts = 0;
    bit hung = 1'b0;

    // fields of the current trace line.
    name_t       t_name;
    logic        t_valid;
    logic [31:0] t_word;
    logic [4:0]  t_alu_op;
    logic [1:0]  t_a_sel;
    logic [2:0]  t_b_sel;
    logic [2:0]  t_mem_size;
    logic [1:0]  t_wb_sel;
    logic        t_illegal, t_mem_req, t_mem_we, t_gpr_we, t_branch, t_jal, t_jalr;

    // result of the previous line, still on the outputs until the next edge.
    logic        prev_valid, prev_illegal, prev_gpr_we;

    initial begin
        clk_i = 1'b0;
        forever begin
            #10;
            clk_i = ~clk_i;
            if (clk_i)
                rise_count++;
            else
                fall_count++;
        end
    end

    decode_stage decode_stage_inst (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .valid_i    (valid_i),
        .instr_i    (instr_i),
        .valid_o    (valid_o),
        .illegal_o  (illegal_o),
        .alu_op_o   (alu_op_o),
        .a_sel_o    (a_sel_o),
        .b_sel_o    (b_sel_o),
        .mem_req_o  (mem_req_o),
        .mem_we_o   (mem_we_o),
        .mem_size_o (mem_size_o),
        .gpr_we_o   (gpr_we_o),
        .wb_sel_o   (wb_sel_o),
        .branch_o   (branch_o),
        .jal_o      (jal_o),
        .jalr_o     (jalr_o)
    );

    // polls the edge counters for two clock periods at most.
    task automatic wait_edge(input bit rising);
        int start;
        int waited;
        start  = rising ? rise_count : fall_count;
        waited = 0;
        while ((rising ? rise_count : fall_count) == start && waited < 40) begin
            #1;
            waited++;
        end
        if ((rising ? rise_count : fall_count) == start) begin
            hung = 1'b1;
            timeouts++;
            $display("timed out waiting for a %0s clock edge", rising ? "rising" : "falling");
        end
    endtask

    task automatic check_alu_op(input name_t tname, input alu_op_e exp, input alu_op_e act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR %0s alu_op expected %0h actual %0h", tname, exp, act);
        end
    endtask

    task automatic check_a_sel(input name_t tname, input a_sel_e exp, input a_sel_e act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR %0s a_sel expected %0h actual %0h", tname, exp, act);
        end
    endtask

    task automatic check_b_sel(input name_t tname, input b_sel_e exp, input b_sel_e act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR %0s b_sel expected %0h actual %0h", tname, exp, act);
        end
    endtask

    task automatic check_mem_size(input name_t tname, input mem_size_e exp,
                                  input mem_size_e act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR %0s mem_size expected %0h actual %0h", tname, exp, act);
        end
    endtask

    task automatic check_wb_sel(input name_t tname, input wb_sel_e exp, input wb_sel_e act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR %0s wb_sel expected %0h actual %0h", tname, exp, act);
        end
    endtask

    task automatic check_flag(input name_t tname, input string field,
                              input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR %0s %0s expected %0b actual %0b", tname, field, exp, act);
        end
    endtask

    task automatic check_controls(input name_t tname, input logic e_valid,
                                  input logic e_ill, input logic e_req, input logic e_we,
                                  input logic e_gpr, input logic e_br, input logic e_jal,
                                  input logic e_jalr);
        check_flag(tname, "valid_o", e_valid, valid_o);
        check_flag(tname, "illegal_o", e_ill, illegal_o);
        check_flag(tname, "mem_req_o", e_req, mem_req_o);
        check_flag(tname, "mem_we_o", e_we, mem_we_o);
        check_flag(tname, "gpr_we_o", e_gpr, gpr_we_o);
        check_flag(tname, "branch_o", e_br, branch_o);
        check_flag(tname, "jal_o", e_jal, jal_o);
        check_flag(tname, "jalr_o", e_jalr, jalr_o);
    endtask

    // drive on the falling edge, sample just after the next rising edge.
    task automatic drive_and_check();
        wait_edge(1'b0);
        if (!hung) begin
            valid_i = t_valid;
            instr_i = t_word;
            // the new word must not reach the outputs before the edge.
            #1;
            check_flag(t_name, "valid_o before edge", prev_valid, valid_o);
            check_flag(t_name, "illegal_o before edge", prev_illegal, illegal_o);
            check_flag(t_name, "gpr_we_o before edge", prev_gpr_we, gpr_we_o);
            wait_edge(1'b1);
        end
        if (hung) begin
            $display("valid_o never came for %0s because the clock stopped", t_name);
        end else begin
            #2;
            check_controls(t_name, t_valid, t_illegal, t_mem_req, t_mem_we, t_gpr_we,
                           t_branch, t_jal, t_jalr);
            if (t_valid) begin
                check_alu_op(t_name, alu_op_e'(t_alu_op), alu_op_o);
                check_a_sel(t_name, a_sel_e'(t_a_sel), a_sel_o);
                check_b_sel(t_name, b_sel_e'(t_b_sel), b_sel_o);
                check_mem_size(t_name, mem_size_e'(t_mem_size), mem_size_o);
                check_wb_sel(t_name, wb_sel_e'(t_wb_sel), wb_sel_o);
            end
        end
        prev_valid   = t_valid;
        prev_illegal = t_illegal;
        prev_gpr_we  = t_gpr_we;
    endtask

    initial begin
        reg [8*160-1:0] line;
        int fd;
        int n;
        int r;
        reset_i = 1'b1;
        valid_i = 1'b0;
        instr_i = '0;
        prev_valid   = 1'b0;
        prev_illegal = 1'b0;
        prev_gpr_we  = 1'b0;
        for (int i = 0; i < 5 && !hung; i++) begin
            wait_edge(1'b1);
            if (!hung) begin
                #2;
                check_controls("reset", 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
            end
        end
        wait_edge(1'b0);
        reset_i = 1'b0;
        fd = $fopen("test/decode_trace.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the trace file test/decode_trace.txt");
        end else begin
            while (!$feof(fd) && !hung) begin
                line = '0;
                r = $fgets(line, fd);
                n = 0;
                if (r != 0) begin
                    n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                t_name, t_valid, t_word, t_alu_op, t_a_sel, t_b_sel,
                                t_mem_size, t_wb_sel, t_illegal, t_mem_req, t_mem_we,
                                t_gpr_we, t_branch, t_jal, t_jalr);
                end
                // comment and blank lines give at most one field.
                if (n == 15) begin
                    drive_and_check();
                end else if (n > 1) begin
                    errors++;
                    $display("a trace line has %0d fields instead of 15", n);
                end
            end
            $fclose(fd);
        end
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

// ==== test/decode_stage_assert.sv ====
`timescale 1ns/1ps

module decode_stage_assert (
    input logic clk_i,
    input logic reset_i,
    input logic dut_valid_i,
    input logic dut_illegal_i,
    input logic dut_mem_req_i,
    input logic dut_mem_we_i,
    input logic dut_gpr_we_i,
    input logic dut_branch_i,
    input logic dut_jal_i,
    input logic dut_jalr_i
);

    logic any_enable;

    assign any_enable = dut_mem_req_i | dut_mem_we_i | dut_gpr_we_i
                      | dut_branch_i | dut_jal_i | dut_jalr_i;

    // enables only ride on a valid result.
    idle_quiet: assert property (@(posedge clk_i) disable iff (reset_i)
        !dut_valid_i |-> !any_enable)
        else $error("enable set while valid_o is low");

    illegal_quiet: assert property (@(posedge clk_i) disable iff (reset_i)
        dut_illegal_i |-> !any_enable)
        else $error("enable set together with illegal_o");

    store_needs_req: assert property (@(posedge clk_i) disable iff (reset_i)
        dut_mem_we_i |-> dut_mem_req_i)
        else $error("mem_we_o without mem_req_o");

    // one kind of control transfer.
    one_jump: assert property (@(posedge clk_i) disable iff (reset_i)
        $onehot0({dut_branch_i, dut_jal_i, dut_jalr_i}))
        else $error("more than one of branch_o, jal_o and jalr_o");

endmodule

bind decode_stage decode_stage_assert decode_stage_assert_inst (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .dut_valid_i   (valid_o),
    .dut_illegal_i (illegal_o),
    .dut_mem_req_i (mem_req_o),
    .dut_mem_we_i  (mem_we_o),
    .dut_gpr_we_i  (gpr_we_o),
    .dut_branch_i  (branch_o),
    .dut_jal_i     (jal_o),
    .dut_jalr_i    (jalr_o)
);

// ==== hw/decode_stage.sv ====
`timescale 1ns/1ps
`include "decoder_params.svh"

module decode_stage import riscv_decoder_pkg::*; (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                valid_i,
    input  logic [`INSTR_W-1:0] instr_i,
    output logic                valid_o,
    output logic                illegal_o,
    output alu_op_e             alu_op_o,
    output a_sel_e              a_sel_o,
    output b_sel_e              b_sel_o,
    output logic                mem_req_o,
    output logic                mem_we_o,
    output mem_size_e           mem_size_o,
    output logic                gpr_we_o,
    output wb_sel_e             wb_sel_o,
    output logic                branch_o,
    output logic                jal_o,
    output logic                jalr_o
);

    instr_u    instr;
    logic      alu_hit, alu_bad, alu_gpr_we;
    alu_op_e   alu_alu_op;
    b_sel_e    alu_b_sel;
    logic      mem_hit, mem_bad, mem_req, mem_we, mem_gpr_we;
    mem_size_e mem_size;
    b_sel_e    mem_b_sel;
    wb_sel_e   mem_wb_sel;
    logic      flow_hit, flow_bad, flow_branch, flow_jal, flow_jalr, flow_gpr_we;
    alu_op_e   flow_alu_op;
    a_sel_e    flow_a_sel;
    b_sel_e    flow_b_sel;

    logic      illegal_d;
    alu_op_e   alu_op_d;
    a_sel_e    a_sel_d;
    b_sel_e    b_sel_d;
    mem_size_e mem_size_d;
    wb_sel_e   wb_sel_d;
    logic      mem_req_d, mem_we_d, gpr_we_d, branch_d, jal_d, jalr_d;

    assign instr = instr_i;

    alu_op_decoder alu_op_decoder_inst (
        .instr_i  (instr),
        .hit_o    (alu_hit),
        .bad_o    (alu_bad),
        .alu_op_o (alu_alu_op),
        .b_sel_o  (alu_b_sel),
        .gpr_we_o (alu_gpr_we)
    );

    mem_op_decoder mem_op_decoder_inst (
        .instr_i    (instr),
        .hit_o      (mem_hit),
        .bad_o      (mem_bad),
        .mem_req_o  (mem_req),
        .mem_we_o   (mem_we),
        .mem_size_o (mem_size),
        .b_sel_o    (mem_b_sel),
        .gpr_we_o   (mem_gpr_we),
        .wb_sel_o   (mem_wb_sel)
    );

    flow_op_decoder flow_op_decoder_inst (
        .instr_i  (instr),
        .hit_o    (flow_hit),
        .bad_o    (flow_bad),
        .alu_op_o (flow_alu_op),
        .a_sel_o  (flow_a_sel),
        .b_sel_o  (flow_b_sel),
        .branch_o (flow_branch),
        .jal_o    (flow_jal),
        .jalr_o   (flow_jalr),
        .gpr_we_o (flow_gpr_we)
    );

    // opcode classes are disjoint, so at most one decoder hits.
    assign illegal_d = ~(alu_hit | mem_hit | flow_hit)
                     | (alu_hit & alu_bad)
                     | (mem_hit & mem_bad)
                     | (flow_hit & flow_bad);

    always_comb begin
        alu_op_d   = ALU_ADD;
        a_sel_d    = OP_A_RS1;
        b_sel_d    = OP_B_RS2;
        mem_size_d = LDST_B;
        wb_sel_d   = WB_EX_RESULT;
        mem_req_d  = 1'b0;
        mem_we_d   = 1'b0;
        gpr_we_d   = 1'b0;
        branch_d   = 1'b0;
        jal_d      = 1'b0;
        jalr_d     = 1'b0;
        if (!illegal_d) begin
            if (alu_hit) begin
                alu_op_d = alu_alu_op;
                b_sel_d  = alu_b_sel;
                gpr_we_d = alu_gpr_we;
            end else if (mem_hit) begin
                b_sel_d    = mem_b_sel;
                mem_req_d  = mem_req;
                mem_we_d   = mem_we;
                mem_size_d = mem_size;
                gpr_we_d   = mem_gpr_we;
                wb_sel_d   = mem_wb_sel;
            end else begin
                alu_op_d = flow_alu_op;
                a_sel_d  = flow_a_sel;
                b_sel_d  = flow_b_sel;
                branch_d = flow_branch;
                jal_d    = flow_jal;
                jalr_d   = flow_jalr;
                gpr_we_d = flow_gpr_we;
            end
        end
    end

    // control bits qualified by valid.
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_o   <= 1'b0;
            illegal_o <= 1'b0;
            mem_req_o <= 1'b0;
            mem_we_o  <= 1'b0;
            gpr_we_o  <= 1'b0;
            branch_o  <= 1'b0;
            jal_o     <= 1'b0;
            jalr_o    <= 1'b0;
        end else begin
            valid_o   <= valid_i;
            illegal_o <= valid_i & illegal_d;
            mem_req_o <= valid_i & mem_req_d;
            mem_we_o  <= valid_i & mem_we_d;
            gpr_we_o  <= valid_i & gpr_we_d;
            branch_o  <= valid_i & branch_d;
            jal_o     <= valid_i & jal_d;
            jalr_o    <= valid_i & jalr_d;
        end
    end

    // operand selects only load on a valid word.
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            alu_op_o   <= alu_op_d;
            a_sel_o    <= a_sel_d;
            b_sel_o    <= b_sel_d;
            mem_size_o <= mem_size_d;
            wb_sel_o   <= wb_sel_d;
        end
    end

endmodule

// ==== hw/flow_op_decoder.sv ====
`timescale 1ns/1ps
`include "decoder_params.svh"

module flow_op_decoder import riscv_decoder_pkg::*; (
    input  instr_u  instr_i,
    output logic    hit_o,
    output logic    bad_o,
    output alu_op_e alu_op_o,
    output a_sel_e  a_sel_o,
    output b_sel_e  b_sel_o,
    output logic    branch_o,
    output logic    jal_o,
    output logic    jalr_o,
    output logic    gpr_we_o
);

    logic f3_zero;

    assign f3_zero = (instr_i.itype.funct3 == `F3_ZERO);

    always_comb begin
        hit_o    = 1'b1;
        bad_o    = 1'b0;
        alu_op_o = ALU_ADD;
        a_sel_o  = OP_A_RS1;
        b_sel_o  = OP_B_RS2;
        branch_o = 1'b0;
        jal_o    = 1'b0;
        jalr_o   = 1'b0;
        gpr_we_o = 1'b0;
        case (instr_i.itype.opcode)
            `OPC_BRANCH: begin
                branch_o = 1'b1;
                case (instr_i.itype.funct3)
                    3'h0:    alu_op_o = ALU_EQ;
                    3'h1:    alu_op_o = ALU_NE;
                    3'h4:    alu_op_o = ALU_LTS;
                    3'h5:    alu_op_o = ALU_GES;
                    3'h6:    alu_op_o = ALU_LTU;
                    3'h7:    alu_op_o = ALU_GEU;
                    default: bad_o = 1'b1;
                endcase
            end
            `OPC_JAL, `OPC_JALR: begin
                // link value is pc + 4.
                a_sel_o  = OP_A_CURR_PC;
                b_sel_o  = OP_B_INCR;
                gpr_we_o = 1'b1;
                jal_o    = (instr_i.itype.opcode == `OPC_JAL);
                jalr_o   = (instr_i.itype.opcode == `OPC_JALR);
                bad_o    = jalr_o & ~f3_zero;
            end
            `OPC_LUI: begin
                a_sel_o  = OP_A_ZERO;
                b_sel_o  = OP_B_IMM_U;
                gpr_we_o = 1'b1;
            end
            `OPC_AUIPC: begin
                a_sel_o  = OP_A_CURR_PC;
                b_sel_o  = OP_B_IMM_U;
                gpr_we_o = 1'b1;
            end
            // fence acts as a nop.
            `OPC_MISC_MEM: bad_o = ~f3_zero;
            default: hit_o = 1'b0;
        endcase
    end

endmodule

// ==== hw/mem_op_decoder.sv ====
`timescale 1ns/1ps
`include "decoder_params.svh"

module mem_op_decoder import riscv_decoder_pkg::*; (
    input  instr_u    instr_i,
    output logic      hit_o,
    output logic      bad_o,
    output logic      mem_req_o,
    output logic      mem_we_o,
    output mem_size_e mem_size_o,
    output b_sel_e    b_sel_o,
    output logic      gpr_we_o,
    output wb_sel_e   wb_sel_o
);

    logic is_load;
    logic is_store;

    assign is_load  = (instr_i.itype.opcode == `OPC_LOAD);
    assign is_store = (instr_i.itype.opcode == `OPC_STORE);

    always_comb begin
        mem_size_o = LDST_B;
        bad_o      = 1'b0;
        if (is_load) begin
            case (instr_i.itype.funct3)
                3'h0:    mem_size_o = LDST_B;
                3'h1:    mem_size_o = LDST_H;
                3'h2:    mem_size_o = LDST_W;
                3'h4:    mem_size_o = LDST_BU;
                3'h5:    mem_size_o = LDST_HU;
                default: bad_o = 1'b1;
            endcase
        end else if (is_store) begin
            // no unsigned stores.
            case (instr_i.itype.funct3)
                3'h0:    mem_size_o = LDST_B;
                3'h1:    mem_size_o = LDST_H;
                3'h2:    mem_size_o = LDST_W;
                default: bad_o = 1'b1;
            endcase
        end
    end

    assign hit_o     = is_load | is_store;
    assign mem_req_o = hit_o;
    assign mem_we_o  = is_store;
    assign b_sel_o   = is_store ? OP_B_IMM_S : OP_B_IMM_I;
    assign gpr_we_o  = is_load;
    assign wb_sel_o  = is_load ? WB_LSU_DATA : WB_EX_RESULT;

endmodule

// ==== hw/alu_op_decoder.sv ====
`timescale 1ns/1ps
`include "decoder_params.svh"

module alu_op_decoder import riscv_decoder_pkg::*; (
    input  instr_u  instr_i,
    output logic    hit_o,
    output logic    bad_o,
    output alu_op_e alu_op_o,
    output b_sel_e  b_sel_o,
    output logic    gpr_we_o
);

    logic                 is_reg;
    logic                 is_imm;
    logic [`FUNCT3_W-1:0] funct3;
    logic [`FUNCT7_W-1:0] funct7;
    logic                 f7_base;
    logic                 f7_alt;
    logic                 alt_ok;
    logic                 f7_checked;

    assign is_reg = (instr_i.rtype.opcode == `OPC_OP);
    assign is_imm = (instr_i.rtype.opcode == `OPC_OP_IMM);
    assign funct3 = instr_i.rtype.funct3;

    // for shift immediates these bits sit above shamt.
    assign funct7  = instr_i.rtype.funct7;
    assign f7_base = (funct7 == `F7_BASE);
    assign f7_alt  = (funct7 == `F7_ALT);

    always_comb begin
        alu_op_o = ALU_ADD;
        alt_ok   = 1'b0;
        case (funct3)
            `F3_ADD_SUB: begin
                alu_op_o = (is_reg && f7_alt) ? ALU_SUB : ALU_ADD;
                alt_ok   = is_reg;
            end
            `F3_SLL:  alu_op_o = ALU_SLL;
            `F3_SLT:  alu_op_o = ALU_SLTS;
            `F3_SLTU: alu_op_o = ALU_SLTU;
            `F3_XOR:  alu_op_o = ALU_XOR;
            `F3_SRL_SRA: begin
                alu_op_o = f7_alt ? ALU_SRA : ALU_SRL;
                alt_ok   = 1'b1;
            end
            `F3_OR:   alu_op_o = ALU_OR;
            `F3_AND:  alu_op_o = ALU_AND;
            default:  alu_op_o = ALU_ADD;
        endcase
    end

    // immediate forms carry imm bits there, except for shifts.
    assign f7_checked = is_reg || (funct3 == `F3_SLL) || (funct3 == `F3_SRL_SRA);

    assign hit_o    = is_reg | is_imm;
    assign bad_o    = hit_o & f7_checked & ~(f7_base | (f7_alt & alt_ok));
    assign b_sel_o  = is_reg ? OP_B_RS2 : OP_B_IMM_I;
    assign gpr_we_o = hit_o;

endmodule

// ==== hw/riscv_decoder_pkg.sv ====
`include "decoder_params.svh"

package riscv_decoder_pkg;

    typedef enum logic [4:0] {
        ALU_ADD  = 5'b00000,
        ALU_SUB  = 5'b01000,
        ALU_XOR  = 5'b00100,
        ALU_OR   = 5'b00110,
        ALU_AND  = 5'b00111,
        ALU_SLL  = 5'b00001,
        ALU_SRL  = 5'b00101,
        ALU_SRA  = 5'b01101,
        ALU_SLTS = 5'b00010,
        ALU_SLTU = 5'b00011,
        ALU_EQ   = 5'b11000,
        ALU_NE   = 5'b11001,
        ALU_LTS  = 5'b11100,
        ALU_GES  = 5'b11101,
        ALU_LTU  = 5'b11110,
        ALU_GEU  = 5'b11111
    } alu_op_e;

    typedef enum logic [1:0] {
        OP_A_RS1     = 2'd0,
        OP_A_CURR_PC = 2'd1,
        OP_A_ZERO    = 2'd2
    } a_sel_e;

    typedef enum logic [2:0] {
        OP_B_RS2   = 3'd0,
        OP_B_IMM_I = 3'd1,
        OP_B_IMM_U = 3'd2,
        OP_B_IMM_S = 3'd3,
        OP_B_INCR  = 3'd4
    } b_sel_e;

    typedef enum logic [1:0] {
        WB_EX_RESULT = 2'd0,
        WB_LSU_DATA  = 2'd1
    } wb_sel_e;

    // matches the load/store funct3 encoding.
    typedef enum logic [2:0] {
        LDST_B  = 3'd0,
        LDST_H  = 3'd1,
        LDST_W  = 3'd2,
        LDST_BU = 3'd4,
        LDST_HU = 3'd5
    } mem_size_e;

    typedef struct packed {
        logic [`FUNCT7_W-1:0]   funct7;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`FUNCT3_W-1:0]   funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`OPCODE_W-1:0]   opcode;
    } r_fields_t;

    typedef struct packed {
        logic [`IMM12_W-1:0]    imm12;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`FUNCT3_W-1:0]   funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`OPCODE_W-1:0]   opcode;
    } i_fields_t;

    typedef union packed {
        r_fields_t rtype;
        i_fields_t itype;
    } instr_u;

endpackage

// ==== include/decoder_params.svh ====
`ifndef DECODER_PARAMS_SVH
`define DECODER_PARAMS_SVH

// instruction word fields.
`define INSTR_W     32
`define OPCODE_W    7
`define FUNCT3_W    3
`define FUNCT7_W    7
`define REG_ADDR_W  5
`define IMM12_W     12

// major opcodes, bits [6:0].
`define OPC_LOAD     7'b0000011
`define OPC_MISC_MEM 7'b0001111
`define OPC_OP_IMM   7'b0010011
`define OPC_AUIPC    7'b0010111
`define OPC_STORE    7'b0100011
`define OPC_OP       7'b0110011
`define OPC_LUI      7'b0110111
`define OPC_BRANCH   7'b1100011
`define OPC_JALR     7'b1100111
`define OPC_JAL      7'b1101111

// funct7 variants.
`define F7_BASE 7'h00
`define F7_ALT  7'h20

// funct3 codes of the integer ALU ops.
`define F3_ADD_SUB 3'h0
`define F3_SLL     3'h1
`define F3_SLT     3'h2
`define F3_SLTU    3'h3
`define F3_XOR     3'h4
`define F3_SRL_SRA 3'h5
`define F3_OR      3'h6
`define F3_AND     3'h7
`define F3_ZERO    3'h0

`endif
